/* filelist.f */
rtl/periph_pkg.sv
rtl/periph_timer.sv
rtl/pwm_modulator.sv
rtl/pin_mux.sv
rtl/periph_reg_file.sv
rtl/peripheral_unit.sv
sim/peripheral_unit_sva.sv
sim/tb_peripheral_unit.sv

/* rtl/periph_pkg.sv */
package periph_pkg;

   localparam int NUM_PINS     = 8;
   localparam int TIM_INST_NUM = 2;
   localparam int PWM_INST_NUM = 2;
   // Timers first, then the combined GPIO interrupt
   localparam int NUM_IRQ      = TIM_INST_NUM + 1;
   localparam int MOD_WIDTH    = 8;

   // 256-byte window
   localparam logic [31:0] BASE_ADDR = 32'h1000_0000;

   //////////////////////////////////////////////////////////////////////
   // Register map, byte offsets inside the window
   //////////////////////////////////////////////////////////////////////
   localparam logic [7:0] GPIO_OUT    = 8'h00;
   localparam logic [7:0] GPIO_IN     = 8'h04;
   localparam logic [7:0] GPIO_DIR    = 8'h08;
   localparam logic [7:0] GPIO_SEL    = 8'h0C;
   localparam logic [7:0] GPIO_IRQEN  = 8'h10;
   localparam logic [7:0] GPIO_IRQPOL = 8'h14;
   localparam logic [7:0] GPIO_IRQ    = 8'h18;
   localparam logic [7:0] P_I_EN      = 8'h1C;
   localparam logic [7:0] IRQ_PEND    = 8'h20;

   localparam logic [7:0] TIM_BASE     = 8'h40;
   localparam logic [7:0] TIM_STRIDE   = 8'h20;
   localparam logic [7:0] TIM_CTRL     = 8'h00;
   localparam logic [7:0] TIM_THRESH_L = 8'h04;
   localparam logic [7:0] TIM_THRESH_H = 8'h08;
   localparam logic [7:0] TIM_OUT_L    = 8'h0C;
   localparam logic [7:0] TIM_OUT_H    = 8'h10;

   localparam logic [7:0] PWM_BASE     = 8'h80;
   localparam logic [7:0] PWM_STRIDE   = 8'h10;
   localparam logic [7:0] PWM_EN       = 8'h00;
   localparam logic [7:0] PWM_DIV      = 8'h04;
   localparam logic [7:0] PWM_SETPOINT = 8'h08;
   localparam logic [7:0] PWM_SR       = 8'h0C;

   // Pin mux selections, 2 and 3 reserved
   localparam logic [1:0] SEL_GPIO = 2'd0;
   localparam logic [1:0] SEL_PWM  = 2'd1;

   //////////////////////////////////////////////////////////////////////
   // Config and status bundles
   //////////////////////////////////////////////////////////////////////
   typedef struct packed {
      logic        en;
      logic        clr;
      logic [63:0] thresh;
   } tim_cfg_t;

   typedef struct packed {
      logic [63:0] mtime;
      logic        irq;
   } tim_stat_t;

   typedef struct packed {
      logic                 en;
      logic [7:0]           div;
      logic [MOD_WIDTH-1:0] setpoint;
      logic                 restart;
   } pwm_cfg_t;

   typedef struct packed {
      logic pwm_out;
      logic busy;
      logic wrap;
   } pwm_stat_t;

   typedef struct packed {
      logic [NUM_PINS-1:0]   out;
      logic [NUM_PINS-1:0]   dir;
      logic [2*NUM_PINS-1:0] sel;
      logic [NUM_PINS-1:0]   irqen;
      logic [NUM_PINS-1:0]   irqpol;
      logic [NUM_PINS-1:0]   irq_clr;
   } gpio_cfg_t;

   typedef struct packed {
      logic [NUM_PINS-1:0] sync_in;
      logic [NUM_PINS-1:0] irq;
   } gpio_stat_t;

endpackage

/* rtl/periph_reg_file.sv */
`timescale 1ns/1ps

module periph_reg_file (
   input  logic                                                     i_clk,
   input  logic                                                     i_arst_n,
   input  logic                                                     i_req,
   input  logic                                                     i_we,
   input  logic [31:0]                                              i_addr,
   input  logic [31:0]                                              i_wdata,
   input  logic [3:0]                                               i_be,
   output logic                                                     o_gnt,
   output logic                                                     o_rvalid,
   output logic [31:0]                                              o_rdata,
   output periph_pkg::tim_cfg_t  [periph_pkg::TIM_INST_NUM-1:0]     o_tim_cfg,
   input  periph_pkg::tim_stat_t [periph_pkg::TIM_INST_NUM-1:0]     i_tim_stat,
   output periph_pkg::pwm_cfg_t  [periph_pkg::PWM_INST_NUM-1:0]     o_pwm_cfg,
   input  periph_pkg::pwm_stat_t [periph_pkg::PWM_INST_NUM-1:0]     i_pwm_stat,
   output periph_pkg::gpio_cfg_t                                    o_gpio_cfg,
   input  periph_pkg::gpio_stat_t                                   i_gpio_stat,
   output logic [periph_pkg::NUM_IRQ-1:0]                           o_p_interrupts,
   output logic [periph_pkg::NUM_IRQ-1:0]                           o_p_i_enable
);

   import periph_pkg::*;

   logic                                   sel_win;
   logic [7:0]                             off;
   logic                                   wr;
   logic [31:0]                            bmask;
   logic [31:0]                            rd_data;
   logic [NUM_IRQ-1:0]                     pend;

   logic [NUM_PINS-1:0]                    gpio_out;
   logic [NUM_PINS-1:0]                    gpio_dir;
   logic [2*NUM_PINS-1:0]                  gpio_sel;
   logic [NUM_PINS-1:0]                    gpio_irqen;
   logic [NUM_PINS-1:0]                    gpio_irqpol;
   logic [NUM_PINS-1:0]                    irq_clr;
   logic [NUM_IRQ-1:0]                     p_i_en;

   logic [TIM_INST_NUM-1:0]                tim_en;
   logic [TIM_INST_NUM-1:0]                tim_clr;
   logic [TIM_INST_NUM-1:0][63:0]          tim_thresh;

   logic [PWM_INST_NUM-1:0]                pwm_en;
   logic [PWM_INST_NUM-1:0]                pwm_restart;
   logic [PWM_INST_NUM-1:0][7:0]           pwm_div;
   logic [PWM_INST_NUM-1:0][MOD_WIDTH-1:0] pwm_set;

   // Offset of register sub inside instance idx of a block
   function automatic logic [7:0] reg_off(input logic [7:0] base, input logic [7:0] stride,
                                          input int idx, input logic [7:0] sub);
      return 8'(base + stride * idx) + sub;
   endfunction

   // Byte-enabled update of a 32-bit view
   function automatic logic [31:0] merge(input logic [31:0] cur);
      return (cur & ~bmask) | (i_wdata & bmask);
   endfunction

   assign o_gnt   = i_req;
   assign sel_win = (i_addr[31:8] == BASE_ADDR[31:8]);
   assign off     = i_addr[7:0];
   assign wr      = i_req && i_we && sel_win;
   assign bmask   = {{8{i_be[3]}}, {8{i_be[2]}}, {8{i_be[1]}}, {8{i_be[0]}}};

   //////////////////////////////////////////////////////////////////////
   // Write decode, control state and one-cycle pulses
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         gpio_out    <= '0;
         gpio_dir    <= '0;
         gpio_sel    <= '0;
         gpio_irqen  <= '0;
         gpio_irqpol <= '0;
         irq_clr     <= '0;
         p_i_en      <= '0;
         tim_en      <= '0;
         tim_clr     <= '0;
         pwm_en      <= '0;
         pwm_restart <= '0;
      end else begin
         irq_clr     <= '0;
         tim_clr     <= '0;
         pwm_restart <= '0;
         if (wr) begin
            case (off)
               GPIO_OUT:    gpio_out    <= NUM_PINS'(merge(32'(gpio_out)));
               GPIO_DIR:    gpio_dir    <= NUM_PINS'(merge(32'(gpio_dir)));
               GPIO_SEL:    gpio_sel    <= (2*NUM_PINS)'(merge(32'(gpio_sel)));
               GPIO_IRQEN:  gpio_irqen  <= NUM_PINS'(merge(32'(gpio_irqen)));
               GPIO_IRQPOL: gpio_irqpol <= NUM_PINS'(merge(32'(gpio_irqpol)));
               GPIO_IRQ:    irq_clr     <= i_wdata[NUM_PINS-1:0] & bmask[NUM_PINS-1:0];
               P_I_EN:      p_i_en      <= NUM_IRQ'(merge(32'(p_i_en)));
               default:     ;
            endcase
            for (int t = 0; t < TIM_INST_NUM; t++) begin
               if (off == reg_off(TIM_BASE, TIM_STRIDE, t, TIM_CTRL)) begin
                  tim_en[t]  <= i_be[0] ? i_wdata[0] : tim_en[t];
                  tim_clr[t] <= 1'b1;
               end
            end
            for (int p = 0; p < PWM_INST_NUM; p++) begin
               if (off == reg_off(PWM_BASE, PWM_STRIDE, p, PWM_EN)) begin
                  pwm_en[p] <= i_be[0] ? i_wdata[0] : pwm_en[p];
               end
               if (off == reg_off(PWM_BASE, PWM_STRIDE, p, PWM_EN) ||
                   off == reg_off(PWM_BASE, PWM_STRIDE, p, PWM_DIV) ||
                   off == reg_off(PWM_BASE, PWM_STRIDE, p, PWM_SETPOINT)) begin
                  pwm_restart[p] <= 1'b1;
               end
            end
         end
      end
   end

   // Thresholds and PWM settings
   always_ff @(posedge i_clk) begin
      if (wr) begin
         for (int t = 0; t < TIM_INST_NUM; t++) begin
            if (off == reg_off(TIM_BASE, TIM_STRIDE, t, TIM_THRESH_L)) begin
               tim_thresh[t][31:0] <= merge(tim_thresh[t][31:0]);
            end
            if (off == reg_off(TIM_BASE, TIM_STRIDE, t, TIM_THRESH_H)) begin
               tim_thresh[t][63:32] <= merge(tim_thresh[t][63:32]);
            end
         end
         for (int p = 0; p < PWM_INST_NUM; p++) begin
            if (off == reg_off(PWM_BASE, PWM_STRIDE, p, PWM_DIV)) begin
               pwm_div[p] <= 8'(merge(32'(pwm_div[p])));
            end
            if (off == reg_off(PWM_BASE, PWM_STRIDE, p, PWM_SETPOINT)) begin
               pwm_set[p] <= MOD_WIDTH'(merge(32'(pwm_set[p])));
            end
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Readback and interrupt gathering
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      for (int t = 0; t < TIM_INST_NUM; t++) begin
         pend[t] = i_tim_stat[t].irq;
      end
      pend[NUM_IRQ-1] = |i_gpio_stat.irq;
   end

   always_comb begin
      case (off)
         GPIO_OUT:    rd_data = 32'(gpio_out);
         GPIO_IN:     rd_data = 32'(i_gpio_stat.sync_in);
         GPIO_DIR:    rd_data = 32'(gpio_dir);
         GPIO_SEL:    rd_data = 32'(gpio_sel);
         GPIO_IRQEN:  rd_data = 32'(gpio_irqen);
         GPIO_IRQPOL: rd_data = 32'(gpio_irqpol);
         GPIO_IRQ:    rd_data = 32'(i_gpio_stat.irq);
         P_I_EN:      rd_data = 32'(p_i_en);
         IRQ_PEND:    rd_data = 32'(pend);
         default:     rd_data = '0;
      endcase
      for (int t = 0; t < TIM_INST_NUM; t++) begin
         if (off == reg_off(TIM_BASE, TIM_STRIDE, t, TIM_CTRL))
            rd_data = 32'(tim_en[t]);
         if (off == reg_off(TIM_BASE, TIM_STRIDE, t, TIM_THRESH_L))
            rd_data = tim_thresh[t][31:0];
         if (off == reg_off(TIM_BASE, TIM_STRIDE, t, TIM_THRESH_H))
            rd_data = tim_thresh[t][63:32];
         if (off == reg_off(TIM_BASE, TIM_STRIDE, t, TIM_OUT_L))
            rd_data = i_tim_stat[t].mtime[31:0];
         if (off == reg_off(TIM_BASE, TIM_STRIDE, t, TIM_OUT_H))
            rd_data = i_tim_stat[t].mtime[63:32];
      end
      for (int p = 0; p < PWM_INST_NUM; p++) begin
         if (off == reg_off(PWM_BASE, PWM_STRIDE, p, PWM_EN))
            rd_data = 32'(pwm_en[p]);
         if (off == reg_off(PWM_BASE, PWM_STRIDE, p, PWM_DIV))
            rd_data = 32'(pwm_div[p]);
         if (off == reg_off(PWM_BASE, PWM_STRIDE, p, PWM_SETPOINT))
            rd_data = 32'(pwm_set[p]);
         if (off == reg_off(PWM_BASE, PWM_STRIDE, p, PWM_SR))
            rd_data = 32'(i_pwm_stat[p]);
      end
      if (!sel_win)
         rd_data = '0;
   end

   // Response one cycle after the grant
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_rvalid       <= 1'b0;
         o_rdata        <= '0;
         o_p_interrupts <= '0;
      end else begin
         o_rvalid       <= i_req;
         o_rdata        <= (i_req && !i_we) ? rd_data : '0;
         o_p_interrupts <= pend;
      end
   end

   assign o_p_i_enable = p_i_en;

   always_comb begin
      for (int t = 0; t < TIM_INST_NUM; t++) begin
         o_tim_cfg[t].en     = tim_en[t];
         o_tim_cfg[t].clr    = tim_clr[t];
         o_tim_cfg[t].thresh = tim_thresh[t];
      end
      for (int p = 0; p < PWM_INST_NUM; p++) begin
         o_pwm_cfg[p].en       = pwm_en[p];
         o_pwm_cfg[p].div      = pwm_div[p];
         o_pwm_cfg[p].setpoint = pwm_set[p];
         o_pwm_cfg[p].restart  = pwm_restart[p];
      end
      o_gpio_cfg.out     = gpio_out;
      o_gpio_cfg.dir     = gpio_dir;
      o_gpio_cfg.sel     = gpio_sel;
      o_gpio_cfg.irqen   = gpio_irqen;
      o_gpio_cfg.irqpol  = gpio_irqpol;
      o_gpio_cfg.irq_clr = irq_clr;
   end

endmodule

/* rtl/periph_timer.sv */
`timescale 1ns/1ps

module periph_timer (
   input  logic                  i_clk,
   input  logic                  i_arst_n,
   input  periph_pkg::tim_cfg_t  i_cfg,
   output periph_pkg::tim_stat_t o_stat
);

   logic [63:0] mtime;
   logic        irq_q;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         mtime <= '0;
         irq_q <= 1'b0;
      end else begin
         // Clear pulse wins over counting
         if (i_cfg.clr) begin
            mtime <= '0;
         end else if (i_cfg.en) begin
            mtime <= mtime + 64'd1;
         end
         irq_q <= i_cfg.en && (mtime >= i_cfg.thresh);
      end
   end

   assign o_stat.mtime = mtime;
   assign o_stat.irq   = irq_q;

endmodule

/* rtl/peripheral_unit.sv */
`timescale 1ns/1ps

module peripheral_unit (
   input  logic                               i_clk,
   input  logic                               i_arst_n,
   // Core bus
   input  logic                               i_req,
   input  logic                               i_we,
   input  logic [31:0]                        i_addr,
   input  logic [31:0]                        i_wdata,
   input  logic [3:0]                         i_be,
   output logic                               o_gnt,
   output logic                               o_rvalid,
   output logic [31:0]                        o_rdata,
   // Interrupts
   output logic                               o_timer_intr,
   output logic [periph_pkg::NUM_IRQ-1:0]     o_p_interrupts,
   output logic [periph_pkg::NUM_IRQ-1:0]     o_p_i_enable,
   // Pins
   input  logic [periph_pkg::NUM_PINS-1:0]    i_io_in,
   output logic [periph_pkg::NUM_PINS-1:0]    o_io_out,
   output logic [periph_pkg::NUM_PINS-1:0]    o_io_oe_n
);

   import periph_pkg::*;

   tim_cfg_t  [TIM_INST_NUM-1:0] tim_cfg;
   tim_stat_t [TIM_INST_NUM-1:0] tim_stat;
   pwm_cfg_t  [PWM_INST_NUM-1:0] pwm_cfg;
   pwm_stat_t [PWM_INST_NUM-1:0] pwm_stat;
   logic      [PWM_INST_NUM-1:0] pwm_out;
   gpio_cfg_t                    gpio_cfg;
   gpio_stat_t                   gpio_stat;

   periph_reg_file u_reg_file (
      .i_clk          (i_clk),
      .i_arst_n       (i_arst_n),
      .i_req          (i_req),
      .i_we           (i_we),
      .i_addr         (i_addr),
      .i_wdata        (i_wdata),
      .i_be           (i_be),
      .o_gnt          (o_gnt),
      .o_rvalid       (o_rvalid),
      .o_rdata        (o_rdata),
      .o_tim_cfg      (tim_cfg),
      .i_tim_stat     (tim_stat),
      .o_pwm_cfg      (pwm_cfg),
      .i_pwm_stat     (pwm_stat),
      .o_gpio_cfg     (gpio_cfg),
      .i_gpio_stat    (gpio_stat),
      .o_p_interrupts (o_p_interrupts),
      .o_p_i_enable   (o_p_i_enable)
   );

   for (genvar g = 0; g < TIM_INST_NUM; g++) begin : g_timer
      periph_timer u_timer (
         .i_clk    (i_clk),
         .i_arst_n (i_arst_n),
         .i_cfg    (tim_cfg[g]),
         .o_stat   (tim_stat[g])
      );
   end

   for (genvar g = 0; g < PWM_INST_NUM; g++) begin : g_pwm
      pwm_modulator u_pwm (
         .i_clk    (i_clk),
         .i_arst_n (i_arst_n),
         .i_cfg    (pwm_cfg[g]),
         .o_stat   (pwm_stat[g])
      );
      assign pwm_out[g] = pwm_stat[g].pwm_out;
   end

   pin_mux u_pin_mux (
      .i_clk     (i_clk),
      .i_arst_n  (i_arst_n),
      .i_cfg     (gpio_cfg),
      .i_pwm_out (pwm_out),
      .o_stat    (gpio_stat),
      .i_io_in   (i_io_in),
      .o_io_out  (o_io_out),
      .o_io_oe_n (o_io_oe_n)
   );

   // Timer 0 also goes straight to the core
   assign o_timer_intr = tim_stat[0].irq;

endmodule

/* rtl/pin_mux.sv */
`timescale 1ns/1ps

module pin_mux (
   input  logic                                i_clk,
   input  logic                                i_arst_n,
   input  periph_pkg::gpio_cfg_t               i_cfg,
   input  logic [periph_pkg::PWM_INST_NUM-1:0] i_pwm_out,
   output periph_pkg::gpio_stat_t              o_stat,
   input  logic [periph_pkg::NUM_PINS-1:0]     i_io_in,
   output logic [periph_pkg::NUM_PINS-1:0]     o_io_out,
   output logic [periph_pkg::NUM_PINS-1:0]     o_io_oe_n
);

   import periph_pkg::*;

   logic [NUM_PINS-1:0] sync_q1;
   logic [NUM_PINS-1:0] sync_q2;
   logic [NUM_PINS-1:0] prev_q;
   logic [NUM_PINS-1:0] edge_hit;
   logic [NUM_PINS-1:0] irq_q;

   // Output select per pin
   always_comb begin
      for (int k = 0; k < NUM_PINS; k++) begin
         case (i_cfg.sel[2*k +: 2])
            SEL_GPIO: o_io_out[k] = i_cfg.out[k];
            SEL_PWM:  o_io_out[k] = i_pwm_out[k % PWM_INST_NUM];
            default:  o_io_out[k] = 1'b0;
         endcase
      end
   end

   assign o_io_oe_n = ~i_cfg.dir;

   // Rising where irqpol is set, falling elsewhere
   assign edge_hit = i_cfg.irqen &
                     (( i_cfg.irqpol &  sync_q2 & ~prev_q) |
                      (~i_cfg.irqpol & ~sync_q2 &  prev_q));

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         sync_q1 <= '0;
         sync_q2 <= '0;
         prev_q  <= '0;
         irq_q   <= '0;
      end else begin
         sync_q1 <= i_io_in;
         sync_q2 <= sync_q1;
         prev_q  <= sync_q2;
         // A new edge beats a clear in the same cycle
         irq_q   <= (irq_q & ~i_cfg.irq_clr) | edge_hit;
      end
   end

   assign o_stat.sync_in = sync_q2;
   assign o_stat.irq     = irq_q;

endmodule

/* rtl/pwm_modulator.sv */
`timescale 1ns/1ps

module pwm_modulator (
   input  logic                  i_clk,
   input  logic                  i_arst_n,
   input  periph_pkg::pwm_cfg_t  i_cfg,
   output periph_pkg::pwm_stat_t o_stat
);

   import periph_pkg::*;

   logic [7:0]           pre_cnt;
   logic [MOD_WIDTH-1:0] mod_cnt;
   logic                 tick;
   logic                 pwm_q;
   logic                 wrap_q;

   // One step of the modulation counter every div+1 cycles
   assign tick = i_cfg.en && (pre_cnt == i_cfg.div);

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pre_cnt <= '0;
         mod_cnt <= '0;
         pwm_q   <= 1'b0;
         wrap_q  <= 1'b0;
      end else begin
         wrap_q <= 1'b0;
         if (i_cfg.restart || !i_cfg.en) begin
            pre_cnt <= '0;
            mod_cnt <= '0;
         end else if (tick) begin
            pre_cnt <= '0;
            mod_cnt <= mod_cnt + 1'b1;
            wrap_q  <= &mod_cnt;
         end else begin
            pre_cnt <= pre_cnt + 8'd1;
         end
         pwm_q <= i_cfg.en && (mod_cnt < i_cfg.setpoint);
      end
   end

   assign o_stat.pwm_out = pwm_q;
   assign o_stat.busy    = i_cfg.en;
   assign o_stat.wrap    = wrap_q;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the peripheral unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal \
   --top-module tb_peripheral_unit \
   -f filelist.f -o tb_peripheral_unit

./obj_dir/tb_peripheral_unit +verilator+error+limit+100 | tee sim.log

if grep -qx "TEST PASSED" sim.log; then
   echo "Simulation passed"
   exit 0
fi
echo "Simulation failed, see sim.log"
exit 1

/* sim/periph_stimulus.txt */
# T name | W addr data be | R addr op(eq/ge/le) value | P pins | O io_out io_oe_n p_interrupts
# C cycles | I max_cycles | U count | D pin window expected tolerance (C I U D in decimal, rest hex)
T regs
W 10000008 000000a5 f
R 10000008 eq 000000a5
W 1000000c 12345678 f
R 1000000c eq 00005678
W 1000000c 0000ab00 2
R 1000000c eq 0000ab78
W 1000001c ffffffff 1
W 1000001c 00000000 e
R 1000001c eq 00000007
R 10000030 eq 00000000
W 20000008 ffffffff f
R 20000008 eq 00000000
R 10000008 eq 000000a5
T gpio
W 10000008 000000ff f
W 1000000c 00000000 f
W 10000000 0000003c f
O 3c 00 0
U 4
W 10000000 00000000 f
O 00 00 0
P 5a
C 4
R 10000004 eq 0000005a
P 00
C 4
R 10000004 eq 00000000
T gpio_irq
W 10000014 00000001 f
W 10000010 00000003 f
P 02
C 5
R 10000018 eq 00000000
P 03
C 5
R 10000018 eq 00000001
O 00 00 4
P 01
C 5
R 10000018 eq 00000003
W 10000018 00000001 f
R 10000018 eq 00000002
W 10000018 00000002 f
R 10000018 eq 00000000
O 00 00 0
W 10000010 00000000 f
P 00
C 4
T timer
W 10000044 00000100 f
W 10000048 00000000 f
W 10000040 00000001 f
I 600
R 1000004c ge 00000100
R 10000020 eq 00000001
W 10000040 00000001 f
R 1000004c le 00000010
W 10000040 00000000 f
C 4
O 00 00 0
T pwm
W 10000084 00000001 f
W 10000088 00000040 f
W 10000080 00000001 f
W 10000094 00000003 f
W 10000098 000000c0 f
W 10000090 00000001 f
R 10000084 eq 00000001
R 10000098 eq 000000c0
W 1000000c 00000005 f
D 0 512 128 2
D 1 1024 768 4
W 10000080 00000000 f
W 10000090 00000000 f
C 2
O 00 00 0

/* sim/peripheral_unit_sva.sv */
`timescale 1ns/1ps

module peripheral_unit_sva (
   input logic        i_clk,
   input logic        i_arst_n,
   input logic        i_req,
   input logic        i_we,
   input logic        o_gnt,
   input logic        o_rvalid,
   input logic [31:0] o_rdata,
   input logic        o_timer_intr
);

   int fail_count = 0;

   // No back-pressure, grant is the request
   a_gnt_with_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      o_gnt |-> i_req)
      else begin
         fail_count++;
         $error("o_gnt high without i_req");
      end

   a_rvalid_after_gnt: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      (i_req && o_gnt) |=> o_rvalid)
      else begin
         fail_count++;
         $error("granted request without o_rvalid one cycle later");
      end

   a_rvalid_has_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      o_rvalid |-> $past(i_req && o_gnt))
      else begin
         fail_count++;
         $error("o_rvalid without a granted request");
      end

   // Read data only in a read response
   a_rdata_idle_zero: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      !(o_rvalid && $past(i_req && !i_we)) |-> (o_rdata == 32'd0))
      else begin
         fail_count++;
         $error("o_rdata not zero outside a read response");
      end

   a_reset_quiet: assert property (@(posedge i_clk)
      !i_arst_n |-> (!o_rvalid && !o_timer_intr))
      else begin
         fail_count++;
         $error("o_rvalid or o_timer_intr high in reset");
      end

endmodule

bind peripheral_unit peripheral_unit_sva u_sva (
   .i_clk        (i_clk),
   .i_arst_n     (i_arst_n),
   .i_req        (i_req),
   .i_we         (i_we),
   .o_gnt        (o_gnt),
   .o_rvalid     (o_rvalid),
   .o_rdata      (o_rdata),
   .o_timer_intr (o_timer_intr)
);

/* sim/tb_peripheral_unit.sv */
`timescale 1ns/1ps

module tb_peripheral_unit;

   import periph_pkg::*;

   localparam string STIM_FILE = "sim/periph_stimulus.txt";
   localparam int    RESP_WAIT = 4;

   logic                i_clk;
   logic                i_arst_n;
   logic                i_req;
   logic                i_we;
   logic [31:0]         i_addr;
   logic [31:0]         i_wdata;
   logic [3:0]          i_be;
   logic                o_gnt;
   logic                o_rvalid;
   logic [31:0]         o_rdata;
   logic                o_timer_intr;
   logic [NUM_IRQ-1:0]  o_p_interrupts;
   logic [NUM_IRQ-1:0]  o_p_i_enable;
   logic [NUM_PINS-1:0] i_io_in;
   logic [NUM_PINS-1:0] o_io_out;
   logic [NUM_PINS-1:0] o_io_oe_n;

   int    budget = 0;
   logic  budget_ready = 1'b0;
   int    checks = 0;
   int    errors = 0;
   int    test_errors = 0;
   int    tests_run = 0;
   int    tests_failed = 0;
   int    accesses = 0;
   int    rvalid_cnt = 0;
   int    sva_fails;
   string test_name = "";

   peripheral_unit i_peripheral_unit (.*);

   always #10 i_clk = ~i_clk;

   // Count response pulses
   always @(negedge i_clk) begin
      if (o_rvalid)
         rvalid_cnt++;
   end

   //////////////////////////////////////////////////////////////////////
   // Checking helpers
   //////////////////////////////////////////////////////////////////////
   task automatic check_value(input string name, input logic [15:0] op,
                              input logic [31:0] got, input logic [31:0] exp);
      logic ok;
      if (op == "ge")
         ok = (got >= exp);
      else if (op == "le")
         ok = (got <= exp);
      else
         ok = (got == exp);
      checks++;
      if (!ok) begin
         $display("error: %s = 0x%08h, expected %s 0x%08h", name, got, op, exp);
         errors++;
         test_errors++;
      end
   endtask

   task automatic note_failure(input string what);
      $display("%s", what);
      errors++;
      test_errors++;
   endtask

   // Test name from a marker line without the line end
   function automatic string marker_name(input string line);
      int n;
      n = line.len();
      while (n > 2 && (line.getc(n - 1) == 8'h0a || line.getc(n - 1) == 8'h0d ||
                       line.getc(n - 1) == 8'h20))
         n--;
      return line.substr(2, n - 1);
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Bus and pin drivers
   //////////////////////////////////////////////////////////////////////
   task automatic bus_access(input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] be,
                             output logic [31:0] rdata);
      int wait_cnt;
      rdata = '0;
      wait_cnt = 0;
      @(posedge i_clk);
      i_req   <= 1'b1;
      i_we    <= we;
      i_addr  <= addr;
      i_wdata <= wdata;
      i_be    <= be;
      // Grant edge
      @(posedge i_clk);
      i_req   <= 1'b0;
      i_we    <= 1'b0;
      accesses++;
      @(negedge i_clk);
      while (!o_rvalid && wait_cnt < RESP_WAIT) begin
         @(negedge i_clk);
         wait_cnt++;
      end
      if (o_rvalid)
         rdata = o_rdata;
      else
         note_failure($sformatf("no bus response for address 0x%08h", addr));
   endtask

   task automatic drive_pins(input logic [NUM_PINS-1:0] value);
      @(posedge i_clk);
      i_io_in <= value;
   endtask

   task automatic gpio_random(input int count);
      logic [NUM_PINS-1:0] pat;
      logic [31:0]         rd;
      for (int i = 0; i < count; i++) begin
         pat = NUM_PINS'($urandom);
         bus_access(1'b1, BASE_ADDR + 32'(GPIO_OUT), 32'(pat), 4'hf, rd);
         check_value("o_io_out", "eq", 32'(o_io_out), 32'(pat));
         bus_access(1'b0, BASE_ADDR + 32'(GPIO_OUT), '0, 4'hf, rd);
         check_value("o_rdata GPIO_OUT", "eq", rd, 32'(pat));
      end
   endtask

   task automatic wait_timer_irq(input int max_cycles);
      int cnt;
      cnt = 0;
      @(negedge i_clk);
      while (!o_timer_intr && cnt < max_cycles) begin
         @(negedge i_clk);
         cnt++;
      end
      if (!o_timer_intr)
         note_failure($sformatf("timer interrupt did not rise within %0d cycles", max_cycles));
   endtask

   task automatic measure_duty(input int pin, input int window, input int exp, input int tol);
      int    cnt;
      string name;
      cnt = 0;
      name = $sformatf("o_io_out[%0d] high cycles", pin);
      repeat (window) begin
         @(negedge i_clk);
         if (o_io_out[pin])
            cnt++;
      end
      check_value(name, "ge", 32'(cnt), 32'(exp - tol));
      check_value(name, "le", 32'(cnt), 32'(exp + tol));
   endtask

   task automatic finish_test();
      if (test_name.len() > 0) begin
         @(posedge i_clk);
         check_value("o_rvalid pulses", "eq", 32'(rvalid_cnt), 32'(accesses));
         tests_run++;
         if (test_errors > 0)
            tests_failed++;
         $display("test %s: %0d errors", test_name, test_errors);
      end
      test_errors = 0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Stimulus file
   //////////////////////////////////////////////////////////////////////
   task automatic scan_budget();
      int    fd;
      int    n;
      int    pin;
      int    cycles;
      string line;
      cycles = 0;
      fd = $fopen(STIM_FILE, "r");
      if (fd != 0) begin
         while ($fgets(line, fd) > 0) begin
            n = 4;
            if (line.getc(0) == "C")
               void'($sscanf(line, "C %d", n));
            else if (line.getc(0) == "I")
               void'($sscanf(line, "I %d", n));
            else if (line.getc(0) == "D")
               void'($sscanf(line, "D %d %d", pin, n));
            else if (line.getc(0) == "U") begin
               void'($sscanf(line, "U %d", n));
               n = 8 * n;
            end
            cycles += n;
         end
         $fclose(fd);
      end
      budget = 2 * cycles + 20;
   endtask

   task automatic run_stimulus();
      int          fd;
      int          n;
      int          win;
      int          exp_cnt;
      int          tol;
      string       line;
      logic [7:0]  cmd;
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] e;
      logic [31:0] v;
      logic [3:0]  be;
      logic [15:0] op;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         note_failure("cannot open the stimulus file");
      end else begin
         while ($fgets(line, fd) > 0) begin
            cmd = line.getc(0);
            case (cmd)
               "T": begin
                  finish_test();
                  test_name = marker_name(line);
               end
               "W": begin
                  void'($sscanf(line, "W %h %h %h", a, d, be));
                  bus_access(1'b1, a, d, be, v);
               end
               "R": begin
                  void'($sscanf(line, "R %h %s %h", a, op, d));
                  bus_access(1'b0, a, '0, 4'hf, v);
                  check_value($sformatf("o_rdata at 0x%08h", a), op, v, d);
                  // The interrupt enable register is also a port
                  if (a == BASE_ADDR + 32'(P_I_EN))
                     check_value("o_p_i_enable", op, 32'(o_p_i_enable), d);
               end
               "P": begin
                  void'($sscanf(line, "P %h", d));
                  drive_pins(NUM_PINS'(d));
               end
               "C": begin
                  void'($sscanf(line, "C %d", n));
                  repeat (n) @(negedge i_clk);
               end
               "O": begin
                  void'($sscanf(line, "O %h %h %h", d, e, v));
                  @(negedge i_clk);
                  check_value("o_io_out", "eq", 32'(o_io_out), d);
                  check_value("o_io_oe_n", "eq", 32'(o_io_oe_n), e);
                  check_value("o_p_interrupts", "eq", 32'(o_p_interrupts), v);
               end
               "D": begin
                  void'($sscanf(line, "D %d %d %d %d", n, win, exp_cnt, tol));
                  measure_duty(n, win, exp_cnt, tol);
               end
               "U": begin
                  void'($sscanf(line, "U %d", n));
                  gpio_random(n);
               end
               "I": begin
                  void'($sscanf(line, "I %d", n));
                  wait_timer_irq(n);
               end
               default: ;
            endcase
         end
         $fclose(fd);
         finish_test();
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence and watchdog
   //////////////////////////////////////////////////////////////////////
   initial begin
      i_clk    = 1'b0;
      i_arst_n = 1'b0;
      i_req    = 1'b0;
      i_we     = 1'b0;
      i_addr   = '0;
      i_wdata  = '0;
      i_be     = '0;
      i_io_in  = '0;
      void'($urandom(32'h45c3d74f));
      scan_budget();
      budget_ready = 1'b1;
      repeat (5) @(posedge i_clk);
      i_arst_n <= 1'b1;
      run_stimulus();
      sva_fails = i_peripheral_unit.u_sva.fail_count;
      if (sva_fails != 0) begin
         $display("bus protocol assertions failed %0d times", sva_fails);
         errors += sva_fails;
      end
      $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      wait (budget_ready);
      repeat (budget) @(posedge i_clk);
      $display("watchdog: the run did not finish within %0d cycles", budget);
      $display("TEST FAILED");
      $finish;
   end

endmodule
